/* design/irig_pkg.sv */
package irig_pkg;

    // pulse classes, encoded as 0, 1 and 2
    typedef enum logic [1:0] {
        sym_zero = 2'd0,
        sym_one  = 2'd1,
        sym_id   = 2'd2
    } irig_sym_t;

    // raw BCD digits as they arrive in the frame
    typedef struct packed {
        logic [3:0] u_sec;
        logic [2:0] d_sec;
        logic [3:0] u_min;
        logic [2:0] d_min;
        logic [3:0] u_hr;
        logic [1:0] d_hr;
        logic [3:0] u_day;
        logic [3:0] d_day;
        logic [1:0] c_day;
    } irig_bcd_t;

    typedef struct packed {
        logic [5:0] sec;
        logic [5:0] min;
        logic [4:0] hr;
        logic [8:0] day;
    } irig_time_t;

    // slots per frame, one frame per second
    localparam int frame_bits = 100;

    // first slot of each BCD field, LSB first
    localparam int pos_u_sec = 1;
    localparam int pos_d_sec = 6;
    localparam int pos_u_min = 10;
    localparam int pos_d_min = 15;
    localparam int pos_u_hr  = 20;
    localparam int pos_d_hr  = 25;
    localparam int pos_u_day = 30;
    localparam int pos_d_day = 35;
    localparam int pos_c_day = 40;

    // last slot holding a field bit
    localparam int last_data_slot = pos_c_day + 1;

endpackage

/* design/irig_bit_parser.sv */
`timescale 1ns/1ps

module irig_bit_parser import irig_pkg::*; #(
    parameter int count_w = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               din,
    input  logic [count_w-1:0] debounce,
    input  logic [count_w-1:0] one_count,
    input  logic [count_w-1:0] id_count,
    output logic               din_clean,
    output irig_sym_t          sym,
    output logic               sym_valid
);

    logic [count_w-1:0] stable_cnt;
    logic [count_w-1:0] width;
    logic               din_clean_q;
    logic               fall;

    assign fall = din_clean_q & ~din_clean;

    // din must hold its new level for debounce cycles before it is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            din_clean  <= 1'b0;
            stable_cnt <= '0;
        end else if (din != din_clean) begin
            if (stable_cnt + 1'b1 >= debounce) begin
                din_clean  <= din;
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end else begin
            // glitch shorter than debounce, start over
            stable_cnt <= '0;
        end
    end

    // high width in cycles, still valid in the cycle of the fall
    always_ff @(posedge clk) begin
        if (rst) begin
            din_clean_q <= 1'b0;
            width       <= '0;
        end else begin
            din_clean_q <= din_clean;
            if (din_clean) begin
                width <= width + 1'b1;
            end else begin
                width <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sym_valid <= 1'b0;
        end else begin
            sym_valid <= fall;
        end
    end

    // widest class wins; anything under one_count is a zero
    always_ff @(posedge clk) begin
        if (fall) begin
            if (width >= id_count) begin
                sym <= sym_id;
            end else if (width >= one_count) begin
                sym <= sym_one;
            end else begin
                sym <= sym_zero;
            end
        end
    end

endmodule

/* design/irig_frame_decoder.sv */
`timescale 1ns/1ps

module irig_frame_decoder import irig_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      calibrate,
    input  logic      cont,
    input  irig_sym_t sym,
    input  logic      sym_valid,
    output irig_bcd_t frame,
    output logic      frame_valid
);

    localparam int slot_w = $clog2(frame_bits);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ref,
        st_collect,
        st_done
    } state_t;

    state_t            state;
    logic              prev_id;
    logic [slot_w-1:0] slot;
    irig_bcd_t         bcd_q;
    logic              data_bit;
    logic              is_id;
    logic              take;

    assign data_bit = (sym == sym_one);
    assign is_id    = (sym == sym_id);
    assign take     = (state == st_collect) && sym_valid;

    function automatic logic in_field(
        input logic [slot_w-1:0] s,
        input int                pos,
        input int                len
    );
        return (int'(s) >= pos) && (int'(s) < pos + len);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            prev_id     <= 1'b0;
            slot        <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            case (state)
                st_idle: begin
                    prev_id <= 1'b0;
                    if (calibrate) begin
                        state <= st_wait_ref;
                    end
                end
                st_wait_ref: begin
                    // reference is slot 99 followed by slot 0
                    if (sym_valid) begin
                        if (prev_id && is_id) begin
                            state   <= st_collect;
                            slot    <= slot_w'(1);
                            prev_id <= 1'b0;
                        end else begin
                            prev_id <= is_id;
                        end
                    end
                end
                st_collect: begin
                    if (sym_valid) begin
                        slot <= slot + 1'b1;
                        if (slot == slot_w'(last_data_slot)) begin
                            frame_valid <= 1'b1;
                            state       <= cont ? st_idle : st_done;
                        end
                    end
                end
                st_done: begin
                    // one-shot, rearmed by a new calibrate
                    if (!calibrate) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // LSB arrives first, so shift each field right from the top
    always_ff @(posedge clk) begin
        if (take) begin
            if (in_field(slot, pos_u_sec, $bits(bcd_q.u_sec))) begin
                bcd_q.u_sec <= {data_bit, bcd_q.u_sec[3:1]};
            end
            if (in_field(slot, pos_d_sec, $bits(bcd_q.d_sec))) begin
                bcd_q.d_sec <= {data_bit, bcd_q.d_sec[2:1]};
            end
            if (in_field(slot, pos_u_min, $bits(bcd_q.u_min))) begin
                bcd_q.u_min <= {data_bit, bcd_q.u_min[3:1]};
            end
            if (in_field(slot, pos_d_min, $bits(bcd_q.d_min))) begin
                bcd_q.d_min <= {data_bit, bcd_q.d_min[2:1]};
            end
            if (in_field(slot, pos_u_hr, $bits(bcd_q.u_hr))) begin
                bcd_q.u_hr <= {data_bit, bcd_q.u_hr[3:1]};
            end
            if (in_field(slot, pos_d_hr, $bits(bcd_q.d_hr))) begin
                bcd_q.d_hr <= {data_bit, bcd_q.d_hr[1]};
            end
            if (in_field(slot, pos_u_day, $bits(bcd_q.u_day))) begin
                bcd_q.u_day <= {data_bit, bcd_q.u_day[3:1]};
            end
            if (in_field(slot, pos_d_day, $bits(bcd_q.d_day))) begin
                bcd_q.d_day <= {data_bit, bcd_q.d_day[3:1]};
            end
            if (in_field(slot, pos_c_day, $bits(bcd_q.c_day))) begin
                bcd_q.c_day <= {data_bit, bcd_q.c_day[1]};
            end
        end
    end

    // fields are complete in the cycle frame_valid is high
    assign frame = bcd_q;

endmodule

/* design/irig_time_convert.sv */
`timescale 1ns/1ps

module irig_time_convert import irig_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  irig_bcd_t  frame,
    input  logic       frame_valid,
    output irig_time_t time_out,
    output logic       bcd_valid
);

    irig_time_t bin;

    // units + 10 * tens (+ 100 * hundreds for the day)
    always_comb begin
        bin.sec = 6'(frame.u_sec) + 6'(frame.d_sec) * 6'd10;
        bin.min = 6'(frame.u_min) + 6'(frame.d_min) * 6'd10;
        bin.hr  = 5'(frame.u_hr) + 5'(frame.d_hr) * 5'd10;
        bin.day = 9'(frame.u_day) + 9'(frame.d_day) * 9'd10
                + 9'(frame.c_day) * 9'd100;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bcd_valid <= 1'b0;
        end else begin
            bcd_valid <= frame_valid;
        end
    end

    // held until the next frame
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            time_out <= bin;
        end
    end

endmodule

/* design/irig_pps_gen.sv */
`timescale 1ns/1ps

module irig_pps_gen import irig_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      din_clean,
    input  irig_sym_t sym,
    input  logic      sym_valid,
    output logic      pps
);

    localparam int cnt_w = $clog2(frame_bits);

    logic             prev_id;
    logic             locked;
    logic             din_q;
    logic             rise;
    logic [cnt_w-1:0] edge_cnt;

    assign rise = din_clean & ~din_q;

    // own reference search, independent of the decoder
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_id <= 1'b0;
            locked  <= 1'b0;
        end else if (sym_valid && !locked) begin
            if (prev_id && sym == sym_id) begin
                locked <= 1'b1;
            end
            prev_id <= (sym == sym_id);
        end
    end

    // lock comes after the reference bit, so edge 100 is the next reference
    always_ff @(posedge clk) begin
        if (rst) begin
            din_q    <= 1'b0;
            edge_cnt <= '0;
            pps      <= 1'b0;
        end else begin
            din_q <= din_clean;
            pps   <= 1'b0;
            if (locked && rise) begin
                if (edge_cnt == cnt_w'(frame_bits - 1)) begin
                    edge_cnt <= '0;
                    pps      <= 1'b1;
                end else begin
                    edge_cnt <= edge_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* design/irig_bcd.sv */
`timescale 1ns/1ps

module irig_bcd import irig_pkg::*; #(
    parameter int count_w = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               din,
    input  logic               calibrate,
    // high to keep decoding frame after frame
    input  logic               cont,
    // kept for compatibility; a pulse under one_count already counts as a zero
    input  logic [count_w-1:0] zero_count,
    input  logic [count_w-1:0] one_count,
    input  logic [count_w-1:0] id_count,
    input  logic [count_w-1:0] debounce,
    output irig_time_t         time_out,
    output logic               bcd_valid,
    output logic               pps
);

    logic      din_clean;
    irig_sym_t sym;
    logic      sym_valid;
    irig_bcd_t frame;
    logic      frame_valid;

    irig_bit_parser #(
        .count_w (count_w)
    ) parser_i (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .debounce  (debounce),
        .one_count (one_count),
        .id_count  (id_count),
        .din_clean (din_clean),
        .sym       (sym),
        .sym_valid (sym_valid)
    );

    irig_frame_decoder decoder_i (
        .clk         (clk),
        .rst         (rst),
        .calibrate   (calibrate),
        .cont        (cont),
        .sym         (sym),
        .sym_valid   (sym_valid),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    irig_time_convert convert_i (
        .clk         (clk),
        .rst         (rst),
        .frame       (frame),
        .frame_valid (frame_valid),
        .time_out    (time_out),
        .bcd_valid   (bcd_valid)
    );

    irig_pps_gen pps_i (
        .clk       (clk),
        .rst       (rst),
        .din_clean (din_clean),
        .sym       (sym),
        .sym_valid (sym_valid),
        .pps       (pps)
    );

endmodule

/* tb/irig_frame_gen.sv */
`timescale 1ns/1ps

module irig_frame_gen import irig_pkg::*; #(
    parameter int slot_len   = 50,
    parameter int zero_len   = 10,
    parameter int id_len     = 40,
    parameter int glitch_len = 2
) (
    input  logic       clk,
    input  logic       run,
    input  irig_time_t tm,
    input  int         one_w,
    input  logic       glitch,
    output logic       din,
    output logic       frame_start
);

    logic [frame_bits-1:0] bits_q;
    int                    one_q;
    logic                  glitch_q;
    logic                  active;
    int                    slot;
    int                    cyc;

    initial begin
        din         = 1'b0;
        frame_start = 1'b0;
        active      = 1'b0;
        slot        = 0;
        cyc         = 0;
    end

    function automatic logic [frame_bits-1:0] place(input logic [frame_bits-1:0] b,
                                                     input int pos, input int len,
                                                     input int val);
        logic [frame_bits-1:0] r;
        r = b;
        for (int i = 0; i < len; i++) begin
            r[pos + i] = val[i];
        end
        return r;
    endfunction

    // decimal digits, LSB first at their slots
    function automatic logic [frame_bits-1:0] encode(input irig_time_t t);
        logic [frame_bits-1:0] b;
        b = '0;
        b = place(b, pos_u_sec, 4, t.sec % 10);
        b = place(b, pos_d_sec, 3, t.sec / 10);
        b = place(b, pos_u_min, 4, t.min % 10);
        b = place(b, pos_d_min, 3, t.min / 10);
        b = place(b, pos_u_hr, 4, t.hr % 10);
        b = place(b, pos_d_hr, 2, t.hr / 10);
        b = place(b, pos_u_day, 4, t.day % 10);
        b = place(b, pos_d_day, 4, (t.day / 10) % 10);
        b = place(b, pos_c_day, 2, t.day / 100);
        return b;
    endfunction

    function automatic logic level(input int s, input int c);
        int   w;
        logic lvl;
        if (s == 0 || s % 10 == 9) begin
            w = id_len;
        end else if (bits_q[s]) begin
            w = one_q;
        end else begin
            w = zero_len;
        end
        lvl = (c < w);
        // dip inside the pulse, blip in the gap, both shorter than debounce
        if (glitch_q && ((c >= 5 && c < 5 + glitch_len) ||
                         (c >= slot_len - 6 && c < slot_len - 6 + glitch_len))) begin
            lvl = ~lvl;
        end
        return lvl;
    endfunction

    always @(posedge clk) begin
        frame_start <= 1'b0;
        if (!run) begin
            active <= 1'b0;
            din    <= 1'b0;
        end else if (!active || (slot == frame_bits - 1 && cyc == slot_len - 1)) begin
            // new frame, settings taken for its whole length
            active      <= 1'b1;
            bits_q      <= encode(tm);
            one_q       <= one_w;
            glitch_q    <= glitch;
            slot        <= 0;
            cyc         <= 0;
            din         <= 1'b1;
            frame_start <= 1'b1;
        end else if (cyc == slot_len - 1) begin
            slot <= slot + 1;
            cyc  <= 0;
            din  <= level(slot + 1, 0);
        end else begin
            cyc <= cyc + 1;
            din <= level(slot, cyc + 1);
        end
    end

endmodule

/* tb/irig_bcd_tb.sv */
`timescale 1ns/1ps

module irig_bcd_tb import irig_pkg::*; ();

    localparam int slot_len     = 50;
    localparam int zero_len     = 10;
    localparam int one_len      = 25;
    localparam int id_len       = 40;
    localparam int debounce_len = 3;
    localparam int one_thr      = 18;
    localparam int id_thr       = 33;
    localparam int n_frames     = 15;
    localparam int frame_cycles = frame_bits * slot_len;
    localparam int limit        = (n_frames + 2) * frame_cycles;

    logic        clk;
    logic        rst;
    logic        din;
    logic        calibrate;
    logic        cont;
    irig_time_t  time_out;
    logic        bcd_valid;
    logic        pps;
    logic        run;
    irig_time_t  gen_tm;
    int          gen_one;
    logic        gen_glitch;
    logic        frame_start;

    irig_time_t  exp_q[$];
    string       name_q[$];
    string       test_name;
    logic [31:0] rng = 32'd61;
    int          val_err = 0;
    int          proto_err = 0;
    int          seq_err = 0;
    int          bcd_count = 0;
    int          n_mark;
    irig_time_t  t;

    // monitor state
    int          tick = 0;
    int          timeout_cnt = 0;
    int          refs = 0;
    bit          gen_running = 0;
    bit          pps_pending = 0;
    int          pps_due;
    int          last_pps;
    bit          last_pps_valid = 0;
    bit          rst_q = 0;
    irig_time_t  exp_t;
    string       exp_name;

    irig_bcd #(
        .count_w (32)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .calibrate  (calibrate),
        .cont       (cont),
        .zero_count (32'(zero_len)),
        .one_count  (32'(one_thr)),
        .id_count   (32'(id_thr)),
        .debounce   (32'(debounce_len)),
        .time_out   (time_out),
        .bcd_valid  (bcd_valid),
        .pps        (pps)
    );

    irig_frame_gen #(
        .slot_len   (slot_len),
        .zero_len   (zero_len),
        .id_len     (id_len),
        .glitch_len (debounce_len - 1)
    ) gen_i (
        .clk         (clk),
        .run         (run),
        .tm          (gen_tm),
        .one_w       (gen_one),
        .glitch      (gen_glitch),
        .din         (din),
        .frame_start (frame_start)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic irig_time_t rand_time();
        irig_time_t r;
        rng = xorshift32(rng);
        r.sec = 6'(rng % 60);
        rng = xorshift32(rng);
        r.min = 6'(rng % 60);
        rng = xorshift32(rng);
        r.hr = 5'(rng % 24);
        rng = xorshift32(rng);
        r.day = 9'(1 + rng % 366);
        return r;
    endfunction

    // returns once the generator has started sending t
    task automatic send_frame(input irig_time_t ft, input irig_time_t ft_exp, input int one_w,
                              input logic glitch, input logic decodes);
        gen_tm     <= ft;
        gen_one    <= one_w;
        gen_glitch <= glitch;
        @(posedge clk);
        while (frame_start !== 1'b1) begin
            @(posedge clk);
        end
        if (decodes) begin
            exp_q.push_back(ft_exp);
            name_q.push_back(test_name);
        end
    endtask

    task automatic send_random(input logic glitch, input logic decodes);
        irig_time_t ft;
        ft = rand_time();
        send_frame(ft, ft, one_len, glitch, decodes);
    endtask

    always @(posedge clk) begin
        timeout_cnt = timeout_cnt + 1;
        if (timeout_cnt >= limit) begin
            $display("timeout after %0d cycles, errors: value %0d, protocol %0d, sequence %0d",
                     limit, val_err, proto_err, seq_err);
            $display("*** FAILED ***");
            $finish;
        end
    end

    always @(posedge clk) begin
        tick = tick + 1;
        if (rst_q) begin
            assert (bcd_valid === 1'b0 && pps === 1'b0) else begin
                proto_err++;
                $display("bcd_valid or pps high during or just after reset");
            end
        end
        rst_q = rst;
        if (rst === 1'b1) begin
            refs           = 0;
            pps_pending    = 0;
            last_pps_valid = 0;
        end
        // a reference needs slot 99 of the frame before
        if (frame_start === 1'b1) begin
            if (gen_running) begin
                refs++;
            end
            gen_running = 1;
            if (refs >= 2) begin
                pps_pending = 1;
                pps_due     = tick + debounce_len + 2;
            end
        end
        if (pps === 1'b1) begin
            assert (pps_pending) else begin
                proto_err++;
                $display("pps outside the window after a reference slot");
            end
            if (last_pps_valid) begin
                assert (tick - last_pps == frame_cycles) else begin
                    val_err++;
                    $display("error pps_spacing: expected %0d actual %0d",
                             frame_cycles, tick - last_pps);
                end
            end
            last_pps       = tick;
            last_pps_valid = 1;
            pps_pending    = 0;
        end else if (pps_pending) begin
            assert (tick <= pps_due) else begin
                proto_err++;
                $display("pps missing after a reference slot");
                pps_pending = 0;
            end
        end
        if (bcd_valid === 1'b1) begin
            bcd_count <= bcd_count + 1;
            assert (exp_q.size() > 0) else begin
                proto_err++;
                $display("bcd_valid with no frame expected");
            end
            if (exp_q.size() > 0) begin
                exp_t    = exp_q.pop_front();
                exp_name = name_q.pop_front();
                assert (time_out === exp_t) else begin
                    val_err++;
                    $display("error %s: expected day %0d %0d:%0d:%0d actual day %0d %0d:%0d:%0d",
                             exp_name, exp_t.day, exp_t.hr, exp_t.min, exp_t.sec,
                             time_out.day, time_out.hr, time_out.min, time_out.sec);
                end
            end
        end
    end

    initial begin
        rst        = 1'b1;
        calibrate  = 1'b0;
        cont       = 1'b0;
        run        = 1'b0;
        gen_tm     = '0;
        gen_one    = one_len;
        gen_glitch = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        calibrate <= 1'b1;
        cont      <= 1'b1;
        run       <= 1'b1;

        // first frame has no reference in front of it
        test_name = "decode";
        send_random(1'b0, 1'b0);
        repeat (3) send_random(1'b0, 1'b1);

        test_name = "one_shot";
        send_random(1'b0, 1'b1);
        cont  <= 1'b0;
        n_mark = bcd_count;
        send_random(1'b0, 1'b0);
        send_random(1'b0, 1'b0);
        calibrate <= 1'b0;
        repeat (2) @(posedge clk);
        calibrate <= 1'b1;
        send_random(1'b0, 1'b1);
        cont <= 1'b1;
        assert (bcd_count - n_mark == 1) else begin
            seq_err++;
            $display("error one_shot: expected 1 actual %0d", bcd_count - n_mark);
        end
        n_mark = bcd_count;

        // at one_count a pulse is a one, one cycle less is a zero
        test_name = "threshold";
        t = rand_time();
        send_frame(t, t, one_thr, 1'b0, 1'b1);
        assert (bcd_count - n_mark == 1) else begin
            seq_err++;
            $display("error one_shot_rearm: expected 1 actual %0d", bcd_count - n_mark);
        end
        t = rand_time();
        send_frame(t, '0, one_thr - 1, 1'b0, 1'b1);

        test_name = "debounce";
        repeat (2) send_random(1'b1, 1'b1);

        test_name = "reset";
        send_random(1'b0, 1'b0);
        repeat (20 * slot_len + slot_len / 2) @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        send_random(1'b0, 1'b1);
        send_random(1'b0, 1'b1);

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (slot_len) @(posedge clk);
        @(negedge clk);
        $display("errors: value %0d, protocol %0d, sequence %0d", val_err, proto_err, seq_err);
        if (val_err + proto_err + seq_err == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* irig_bcd.f */
design/irig_pkg.sv
design/irig_bit_parser.sv
design/irig_frame_decoder.sv
design/irig_time_convert.sv
design/irig_pps_gen.sv
design/irig_bcd.sv
tb/irig_frame_gen.sv
tb/irig_bcd_tb.sv
